// File: logic/cpu_pkg.sv
// ----------------------------------------------------------------------
// Shared types and encodings for the execute stage of the CPU.
// Import with cpu_pkg::* in module bodies and use scoped names in ports.
// ----------------------------------------------------------------------

package cpu_pkg;

	// widths.
	localparam int WORD_DATA_W = 32;
	localparam int REG_ADDR_W  = 5;
	localparam int MEM_OP_W    = 4;
	localparam int ALU_OP_W    = 4;
	localparam int CMP_OP_W    = 3;
	localparam int SHAMT_W     = 5;  // shift amount, low bits of operand b.

	typedef logic [WORD_DATA_W-1:0] word_data_t;
	typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
	typedef logic [MEM_OP_W-1:0]    mem_op_t;
	typedef logic [ALU_OP_W-1:0]    alu_op_t;
	typedef logic [CMP_OP_W-1:0]    cmp_op_t;
	typedef logic [SHAMT_W-1:0]     shamt_t;

	// enable levels.
	localparam logic ENABLE    = 1'b1;
	localparam logic DISABLE   = 1'b0;
	localparam logic ENABLE_N  = 1'b0;  // active-low write enable.
	localparam logic DISABLE_N = 1'b1;

	// memory ops, upper two bits are the access class.
	localparam logic [1:0] MEM_CLASS_NONE = 2'b00;

	localparam mem_op_t MEM_OP_NOP = 4'b0000;
	localparam mem_op_t MEM_OP_LDW = 4'b0100;  // loads.
	localparam mem_op_t MEM_OP_LDH = 4'b0101;
	localparam mem_op_t MEM_OP_LDB = 4'b0110;
	localparam mem_op_t MEM_OP_STW = 4'b1000;  // stores.
	localparam mem_op_t MEM_OP_STH = 4'b1001;
	localparam mem_op_t MEM_OP_STB = 4'b1010;

	// alu ops.
	localparam alu_op_t ALU_OP_NOP = 4'h0;  // passes operand a.
	localparam alu_op_t ALU_OP_ADD = 4'h1;
	localparam alu_op_t ALU_OP_SUB = 4'h2;
	localparam alu_op_t ALU_OP_AND = 4'h3;
	localparam alu_op_t ALU_OP_OR  = 4'h4;
	localparam alu_op_t ALU_OP_XOR = 4'h5;
	localparam alu_op_t ALU_OP_SLL = 4'h6;
	localparam alu_op_t ALU_OP_SRL = 4'h7;
	localparam alu_op_t ALU_OP_SRA = 4'h8;

	// compare ops, none selects the alu result.
	localparam cmp_op_t CMP_OP_NONE = 3'h0;
	localparam cmp_op_t CMP_OP_EQ   = 3'h1;
	localparam cmp_op_t CMP_OP_NE   = 3'h2;
	localparam cmp_op_t CMP_OP_LT   = 3'h3;  // signed.
	localparam cmp_op_t CMP_OP_LTU  = 3'h4;  // unsigned.

	// bubble values loaded on reset and flush.
	localparam word_data_t WORD_ZERO = '0;
	localparam reg_addr_t  ADDR_ZERO = '0;

endpackage

// File: logic/ex_alu.sv
// ----------------------------------------------------------------------
// Combinational ALU of the execute stage.
// Add, subtract, bitwise logic and shifts, no latency.
// ----------------------------------------------------------------------

module ex_alu (
	input  cpu_pkg::alu_op_t    alu_op,
	input  cpu_pkg::word_data_t alu_a,
	input  cpu_pkg::word_data_t alu_b,
	output cpu_pkg::word_data_t alu_result
);

	import cpu_pkg::*;

	shamt_t shamt;

	assign shamt = alu_b[SHAMT_W-1:0];  // shift by low five bits only.

	always_comb begin
		case (alu_op)
			ALU_OP_NOP: begin
				alu_result = alu_a;
			end
			ALU_OP_ADD: begin
				alu_result = alu_a + alu_b;
			end
			ALU_OP_SUB: begin
				alu_result = alu_a - alu_b;
			end
			ALU_OP_AND: begin
				alu_result = alu_a & alu_b;
			end
			ALU_OP_OR: begin
				alu_result = alu_a | alu_b;
			end
			ALU_OP_XOR: begin
				alu_result = alu_a ^ alu_b;
			end
			ALU_OP_SLL: begin
				alu_result = alu_a << shamt;
			end
			ALU_OP_SRL: begin
				alu_result = alu_a >> shamt;
			end
			ALU_OP_SRA: begin
				// sign bit fills from the left.
				alu_result = word_data_t'($signed(alu_a) >>> shamt);
			end
			default: begin
				alu_result = WORD_ZERO;
				// unknown codes show up before reset, only real codes are flagged.
				assert ($isunknown(alu_op))
				else $error("ex_alu: undefined alu op %h", alu_op);
			end
		endcase
	end

endmodule

// File: logic/ex_cmp.sv
// ----------------------------------------------------------------------
// Compare unit of the execute stage.
// Produces the set-on-compare flag and picks the stage result.
// ----------------------------------------------------------------------

module ex_cmp (
	input  cpu_pkg::cmp_op_t    cmp_op,
	input  cpu_pkg::word_data_t cmp_a,
	input  cpu_pkg::word_data_t cmp_b,
	input  cpu_pkg::word_data_t alu_result,
	output cpu_pkg::word_data_t ex_out_inner
);

	import cpu_pkg::*;

	logic flag;

	always_comb begin
		case (cmp_op)
			CMP_OP_EQ:  flag = (cmp_a == cmp_b);
			CMP_OP_NE:  flag = (cmp_a != cmp_b);
			CMP_OP_LT:  flag = ($signed(cmp_a) < $signed(cmp_b));
			CMP_OP_LTU: flag = (cmp_a < cmp_b);  // plain vectors compare unsigned.
			default:    flag = 1'b0;
		endcase
	end

	// flag is zero-extended to a full word.
	always_comb begin
		if (cmp_op != CMP_OP_NONE) begin
			ex_out_inner = word_data_t'(flag);
		end else begin
			ex_out_inner = alu_result;
		end
	end

endmodule

// File: logic/ex_reg.sv
// ----------------------------------------------------------------------
// EX/MEM pipeline register with stall and flush.
// Also decodes the memory-access mark for load-use detection in decode.
// ----------------------------------------------------------------------

module ex_reg (
	input  logic                clk,
	input  logic                reset,
	input  logic                stall,
	input  logic                flush,
	input  cpu_pkg::word_data_t ex_out_inner,
	input  logic                id_en,
	input  cpu_pkg::mem_op_t    id_mem_op,
	input  cpu_pkg::word_data_t id_mem_wr_data,
	input  cpu_pkg::reg_addr_t  id_dst_addr,
	input  logic                id_gpr_we_n,
	output logic                ex_en,
	output cpu_pkg::mem_op_t    ex_mem_op,
	output cpu_pkg::word_data_t ex_mem_wr_data,
	output cpu_pkg::reg_addr_t  ex_dst_addr,
	output logic                ex_gpr_we_n,
	output cpu_pkg::word_data_t ex_out,
	output logic                access_mem
);

	import cpu_pkg::*;

	// any load or store class marks a memory access.
	assign access_mem = (id_mem_op[MEM_OP_W-1:MEM_OP_W-2] != MEM_CLASS_NONE);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ex_en          <= DISABLE;
			ex_mem_op      <= MEM_OP_NOP;
			ex_mem_wr_data <= WORD_ZERO;
			ex_dst_addr    <= ADDR_ZERO;
			ex_gpr_we_n    <= DISABLE_N;
			ex_out         <= WORD_ZERO;
		end else if (!stall) begin  // stall wins over flush.
			if (flush) begin
				// insert a bubble.
				ex_en          <= DISABLE;
				ex_mem_op      <= MEM_OP_NOP;
				ex_mem_wr_data <= WORD_ZERO;
				ex_dst_addr    <= ADDR_ZERO;
				ex_gpr_we_n    <= DISABLE_N;
				ex_out         <= WORD_ZERO;
			end else begin
				ex_en          <= id_en;
				ex_mem_op      <= id_mem_op;
				ex_mem_wr_data <= id_mem_wr_data;
				ex_dst_addr    <= id_dst_addr;
				ex_gpr_we_n    <= id_gpr_we_n;
				ex_out         <= ex_out_inner;
			end
		end
	end

	// a flushed slot never enables or writes back in the next stage.
	flush_gives_bubble: assert property (
		@(posedge clk) disable iff (reset)
		(!stall && flush) |=> (ex_en == DISABLE && ex_gpr_we_n == DISABLE_N)
	) else $error("ex_reg: flush did not produce a bubble");

	// everything downstream sees a frozen slot under stall.
	stall_holds_outputs: assert property (
		@(posedge clk) disable iff (reset)
		stall |=> ($stable(ex_en) && $stable(ex_mem_op) && $stable(ex_mem_wr_data)
			&& $stable(ex_dst_addr) && $stable(ex_gpr_we_n) && $stable(ex_out))
	) else $error("ex_reg: outputs changed during stall");

endmodule

// File: logic/ex_stage.sv
// ----------------------------------------------------------------------
// Execute stage top level, between the ID/EX and EX/MEM registers.
// ALU and compare feed the pipeline register, one cycle of latency.
// ----------------------------------------------------------------------

module ex_stage (
	input  logic                clk,
	input  logic                reset,
	input  logic                stall,
	input  logic                flush,
	input  logic                id_en,
	input  cpu_pkg::alu_op_t    id_alu_op,
	input  cpu_pkg::word_data_t id_alu_a,
	input  cpu_pkg::word_data_t id_alu_b,
	input  cpu_pkg::cmp_op_t    id_cmp_op,
	input  cpu_pkg::mem_op_t    id_mem_op,
	input  cpu_pkg::word_data_t id_mem_wr_data,
	input  cpu_pkg::reg_addr_t  id_dst_addr,
	input  logic                id_gpr_we_n,
	output logic                ex_en,
	output cpu_pkg::mem_op_t    ex_mem_op,
	output cpu_pkg::word_data_t ex_mem_wr_data,
	output cpu_pkg::reg_addr_t  ex_dst_addr,
	output logic                ex_gpr_we_n,
	output cpu_pkg::word_data_t ex_out,
	output logic                access_mem
);

	import cpu_pkg::*;

	word_data_t alu_result;
	word_data_t ex_out_inner;  // selected result, before the register.

	ex_alu u_alu (
		.alu_op     (id_alu_op),
		.alu_a      (id_alu_a),
		.alu_b      (id_alu_b),
		.alu_result (alu_result)
	);

	// compares the same operands the ALU sees.
	ex_cmp u_cmp (
		.cmp_op       (id_cmp_op),
		.cmp_a        (id_alu_a),
		.cmp_b        (id_alu_b),
		.alu_result   (alu_result),
		.ex_out_inner (ex_out_inner)
	);

	ex_reg u_reg (
		.clk            (clk),
		.reset          (reset),
		.stall          (stall),
		.flush          (flush),
		.ex_out_inner   (ex_out_inner),
		.id_en          (id_en),
		.id_mem_op      (id_mem_op),
		.id_mem_wr_data (id_mem_wr_data),
		.id_dst_addr    (id_dst_addr),
		.id_gpr_we_n    (id_gpr_we_n),
		.ex_en          (ex_en),
		.ex_mem_op      (ex_mem_op),
		.ex_mem_wr_data (ex_mem_wr_data),
		.ex_dst_addr    (ex_dst_addr),
		.ex_gpr_we_n    (ex_gpr_we_n),
		.ex_out         (ex_out),
		.access_mem     (access_mem)
	);

endmodule

// File: dv/ex_stage_vectors.svh
// ----------------------------------------------------------------------
// Stimulus and expected values for the execute stage testbench.
// Included inside ex_stage_tb after the vec_row_t typedef.
// ----------------------------------------------------------------------

`ifndef EX_STAGE_VECTORS_SVH
`define EX_STAGE_VECTORS_SVH

// one row per cycle, three lines each.
// stall, flush, rand_ops, en, alu_op, a, b, cmp_op
// mem_op, wr_data, dst, we_n, exp_access
// exp_en, exp_mem_op, exp_wr_data, exp_dst, exp_we_n, exp_out
localparam int NUM_ROWS = 26;

localparam vec_row_t VECTORS [NUM_ROWS] = '{
	// alu ops with loads and stores riding along.
	'{1'b0, 1'b0, 1'b0, 1'b1, ALU_OP_ADD, 32'h00000005, 32'h00000007, CMP_OP_NONE,
	  MEM_OP_NOP, 32'h00000000, 5'd1, 1'b0, 1'b0,
	  1'b1, MEM_OP_NOP, 32'h00000000, 5'd1, 1'b0, 32'h0000000c},
	'{1'b0, 1'b0, 1'b0, 1'b1, ALU_OP_SUB, 32'h00000003, 32'h00000005, CMP_OP_NONE,
	  MEM_OP_LDW, 32'h00000000, 5'd2, 1'b0, 1'b1,
	  1'b1, MEM_OP_LDW, 32'h00000000, 5'd2, 1'b0, 32'hfffffffe},
	'{1'b0, 1'b0, 1'b0, 1'b1, ALU_OP_AND, 32'hf0f0ff00, 32'h0ff00ff0, CMP_OP_NONE,
	  MEM_OP_LDH, 32'h00000000, 5'd3, 1'b0, 1'b1,
	  1'b1, MEM_OP_LDH, 32'h00000000, 5'd3, 1'b0, 32'h00f00f00},
	'{1'b0, 1'b0, 1'b0, 1'b1, ALU_OP_OR, 32'hf0f00000, 32'h00000f0f, CMP_OP_NONE,
	  MEM_OP_LDB, 32'h00000000, 5'd4, 1'b0, 1'b1,
	  1'b1, MEM_OP_LDB, 32'h00000000, 5'd4, 1'b0, 32'hf0f00f0f},
	'{1'b0, 1'b0, 1'b0, 1'b1, ALU_OP_XOR, 32'haaaa5555, 32'hffff0000, CMP_OP_NONE,
	  MEM_OP_STW, 32'hdeadbeef, 5'd0, 1'b1, 1'b1,
	  1'b1, MEM_OP_STW, 32'hdeadbeef, 5'd0, 1'b1, 32'h55555555},
	'{1'b0, 1'b0, 1'b0, 1'b1, ALU_OP_SLL, 32'h00000001, 32'h00000024, CMP_OP_NONE,
	  MEM_OP_STH, 32'h00001234, 5'd0, 1'b1, 1'b1,
	  1'b1, MEM_OP_STH, 32'h00001234, 5'd0, 1'b1, 32'h00000010},
	'{1'b0, 1'b0, 1'b0, 1'b1, ALU_OP_SRL, 32'h80000000, 32'h0000001f, CMP_OP_NONE,
	  MEM_OP_STB, 32'h000000ab, 5'd0, 1'b1, 1'b1,
	  1'b1, MEM_OP_STB, 32'h000000ab, 5'd0, 1'b1, 32'h00000001},
	'{1'b0, 1'b0, 1'b0, 1'b1, ALU_OP_SRA, 32'h80000000, 32'h00000004, CMP_OP_NONE,
	  MEM_OP_NOP, 32'h00000000, 5'd5, 1'b0, 1'b0,
	  1'b1, MEM_OP_NOP, 32'h00000000, 5'd5, 1'b0, 32'hf8000000},
	'{1'b0, 1'b0, 1'b0, 1'b1, ALU_OP_NOP, 32'h12345678, 32'hffffffff, CMP_OP_NONE,
	  MEM_OP_NOP, 32'h00000000, 5'd6, 1'b0, 1'b0,
	  1'b1, MEM_OP_NOP, 32'h00000000, 5'd6, 1'b0, 32'h12345678},
	// compares, signed and unsigned disagree on 11/12 and 13/14.
	'{1'b0, 1'b0, 1'b0, 1'b1, ALU_OP_ADD, 32'h00000009, 32'h00000009, CMP_OP_EQ,
	  MEM_OP_NOP, 32'h00000000, 5'd7, 1'b0, 1'b0,
	  1'b1, MEM_OP_NOP, 32'h00000000, 5'd7, 1'b0, 32'h00000001},
	'{1'b0, 1'b0, 1'b0, 1'b1, ALU_OP_SUB, 32'h00000009, 32'h00000009, CMP_OP_NE,
	  MEM_OP_NOP, 32'h00000000, 5'd8, 1'b0, 1'b0,
	  1'b1, MEM_OP_NOP, 32'h00000000, 5'd8, 1'b0, 32'h00000000},
	'{1'b0, 1'b0, 1'b0, 1'b1, ALU_OP_NOP, 32'hffffffff, 32'h00000001, CMP_OP_LT,
	  MEM_OP_NOP, 32'h00000000, 5'd9, 1'b0, 1'b0,
	  1'b1, MEM_OP_NOP, 32'h00000000, 5'd9, 1'b0, 32'h00000001},
	'{1'b0, 1'b0, 1'b0, 1'b1, ALU_OP_NOP, 32'hffffffff, 32'h00000001, CMP_OP_LTU,
	  MEM_OP_NOP, 32'h00000000, 5'd10, 1'b0, 1'b0,
	  1'b1, MEM_OP_NOP, 32'h00000000, 5'd10, 1'b0, 32'h00000000},
	'{1'b0, 1'b0, 1'b0, 1'b1, ALU_OP_NOP, 32'h00000001, 32'h80000000, CMP_OP_LT,
	  MEM_OP_NOP, 32'h00000000, 5'd11, 1'b0, 1'b0,
	  1'b1, MEM_OP_NOP, 32'h00000000, 5'd11, 1'b0, 32'h00000000},
	'{1'b0, 1'b0, 1'b0, 1'b1, ALU_OP_NOP, 32'h00000001, 32'h80000000, CMP_OP_LTU,
	  MEM_OP_NOP, 32'h00000000, 5'd12, 1'b0, 1'b0,
	  1'b1, MEM_OP_NOP, 32'h00000000, 5'd12, 1'b0, 32'h00000001},
	// stalled rows hold the row above, flush included.
	'{1'b1, 1'b0, 1'b0, 1'b1, ALU_OP_ADD, 32'h00000001, 32'h00000001, CMP_OP_NONE,
	  MEM_OP_LDW, 32'h00000000, 5'd13, 1'b0, 1'b1,
	  1'b1, MEM_OP_NOP, 32'h00000000, 5'd12, 1'b0, 32'h00000001},
	'{1'b1, 1'b1, 1'b0, 1'b1, ALU_OP_ADD, 32'h00000001, 32'h00000001, CMP_OP_NONE,
	  MEM_OP_STW, 32'h11111111, 5'd0, 1'b1, 1'b1,
	  1'b1, MEM_OP_NOP, 32'h00000000, 5'd12, 1'b0, 32'h00000001},
	'{1'b1, 1'b0, 1'b0, 1'b0, ALU_OP_NOP, 32'h00000000, 32'h00000000, CMP_OP_NONE,
	  MEM_OP_NOP, 32'h00000000, 5'd14, 1'b1, 1'b0,
	  1'b1, MEM_OP_NOP, 32'h00000000, 5'd12, 1'b0, 32'h00000001},
	// flushed rows become bubbles.
	'{1'b0, 1'b1, 1'b0, 1'b1, ALU_OP_ADD, 32'h00000002, 32'h00000003, CMP_OP_NONE,
	  MEM_OP_LDW, 32'h00000000, 5'd15, 1'b0, 1'b1,
	  1'b0, MEM_OP_NOP, 32'h00000000, 5'd0, 1'b1, 32'h00000000},
	'{1'b0, 1'b1, 1'b0, 1'b1, ALU_OP_SUB, 32'h00000005, 32'h00000006, CMP_OP_LTU,
	  MEM_OP_STB, 32'h000000cd, 5'd0, 1'b1, 1'b1,
	  1'b0, MEM_OP_NOP, 32'h00000000, 5'd0, 1'b1, 32'h00000000},
	'{1'b0, 1'b0, 1'b0, 1'b1, ALU_OP_ADD, 32'h00000010, 32'h00000020, CMP_OP_NONE,
	  MEM_OP_NOP, 32'h00000000, 5'd16, 1'b0, 1'b0,
	  1'b1, MEM_OP_NOP, 32'h00000000, 5'd16, 1'b0, 32'h00000030},
	// random operands, exp_out filled in by the model.
	'{1'b0, 1'b0, 1'b1, 1'b1, ALU_OP_ADD, 32'h00000000, 32'h00000000, CMP_OP_NONE,
	  MEM_OP_NOP, 32'h00000000, 5'd17, 1'b0, 1'b0,
	  1'b1, MEM_OP_NOP, 32'h00000000, 5'd17, 1'b0, 32'h00000000},
	'{1'b0, 1'b0, 1'b1, 1'b1, ALU_OP_SUB, 32'h00000000, 32'h00000000, CMP_OP_LT,
	  MEM_OP_NOP, 32'h00000000, 5'd18, 1'b0, 1'b0,
	  1'b1, MEM_OP_NOP, 32'h00000000, 5'd18, 1'b0, 32'h00000000},
	'{1'b0, 1'b0, 1'b1, 1'b1, ALU_OP_SRA, 32'h00000000, 32'h00000000, CMP_OP_NONE,
	  MEM_OP_LDW, 32'h00000000, 5'd19, 1'b0, 1'b1,
	  1'b1, MEM_OP_LDW, 32'h00000000, 5'd19, 1'b0, 32'h00000000},
	'{1'b0, 1'b0, 1'b1, 1'b1, ALU_OP_NOP, 32'h00000000, 32'h00000000, CMP_OP_LTU,
	  MEM_OP_STW, 32'h0000cafe, 5'd0, 1'b1, 1'b1,
	  1'b1, MEM_OP_STW, 32'h0000cafe, 5'd0, 1'b1, 32'h00000000},
	// idle slot at the end.
	'{1'b0, 1'b0, 1'b0, 1'b0, ALU_OP_NOP, 32'h00000000, 32'h00000000, CMP_OP_NONE,
	  MEM_OP_NOP, 32'h00000000, 5'd0, 1'b1, 1'b0,
	  1'b0, MEM_OP_NOP, 32'h00000000, 5'd0, 1'b1, 32'h00000000}
};

`endif

// File: dv/ex_stage_tb.sv
// ----------------------------------------------------------------------
// Testbench for the execute stage. Applies the vector table one row
// per cycle, checks access_mem in the same cycle and the EX/MEM
// outputs one cycle later.
// ----------------------------------------------------------------------

module ex_stage_tb;

	import cpu_pkg::*;

	typedef struct packed {
		logic       stall;
		logic       flush;
		logic       rand_ops;     // operands from $random, result from the model.
		logic       en;
		alu_op_t    alu_op;
		word_data_t a;
		word_data_t b;
		cmp_op_t    cmp_op;
		mem_op_t    mem_op;
		word_data_t wr_data;
		reg_addr_t  dst;
		logic       we_n;
		logic       exp_access;   // same cycle.
		logic       exp_en;       // registered, one cycle later.
		mem_op_t    exp_mem_op;
		word_data_t exp_wr_data;
		reg_addr_t  exp_dst;
		logic       exp_we_n;
		word_data_t exp_out;
	} vec_row_t;

	`include "ex_stage_vectors.svh"

	localparam int RESET_CYCLES = 10;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + 2 * NUM_ROWS + 20;

	// idle inputs and the outputs expected after reset or flush.
	localparam vec_row_t BUBBLE_ROW = '{1'b0, 1'b0, 1'b0, 1'b0, ALU_OP_NOP, WORD_ZERO,
		WORD_ZERO, CMP_OP_NONE, MEM_OP_NOP, WORD_ZERO, ADDR_ZERO, 1'b1, 1'b0,
		1'b0, MEM_OP_NOP, WORD_ZERO, ADDR_ZERO, 1'b1, WORD_ZERO};

	logic       clk = 1'b0;
	logic       reset;
	logic       stall;
	logic       flush;
	logic       id_en;
	alu_op_t    id_alu_op;
	word_data_t id_alu_a;
	word_data_t id_alu_b;
	cmp_op_t    id_cmp_op;
	mem_op_t    id_mem_op;
	word_data_t id_mem_wr_data;
	reg_addr_t  id_dst_addr;
	logic       id_gpr_we_n;
	logic       ex_en;
	mem_op_t    ex_mem_op;
	word_data_t ex_mem_wr_data;
	reg_addr_t  ex_dst_addr;
	logic       ex_gpr_we_n;
	word_data_t ex_out;
	logic       access_mem;

	int seed   = 32'hc057;
	int cycles = 0;
	int errors = 0;

	ex_stage uut (
		.clk            (clk),
		.reset          (reset),
		.stall          (stall),
		.flush          (flush),
		.id_en          (id_en),
		.id_alu_op      (id_alu_op),
		.id_alu_a       (id_alu_a),
		.id_alu_b       (id_alu_b),
		.id_cmp_op      (id_cmp_op),
		.id_mem_op      (id_mem_op),
		.id_mem_wr_data (id_mem_wr_data),
		.id_dst_addr    (id_dst_addr),
		.id_gpr_we_n    (id_gpr_we_n),
		.ex_en          (ex_en),
		.ex_mem_op      (ex_mem_op),
		.ex_mem_wr_data (ex_mem_wr_data),
		.ex_dst_addr    (ex_dst_addr),
		.ex_gpr_we_n    (ex_gpr_we_n),
		.ex_out         (ex_out),
		.access_mem     (access_mem)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Something failed");
			$fatal(1, "timeout");
		end
	end

	task automatic check_value(input string name, input word_data_t expected,
			input word_data_t actual);
		if (actual !== expected) begin
			errors++;
			$display("** Error: %s expected %h actual %h", name, expected, actual);
			$display("Something failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// expected result worked out from the instruction rules.
	function automatic word_data_t model_result(input alu_op_t op, input cmp_op_t cop,
			input word_data_t a, input word_data_t b);
		logic [63:0] ext;
		int unsigned sh;
		logic        lt_s;
		word_data_t  r;
		sh = b % 32;
		ext = {{32{a[31]}}, a} >> sh;
		lt_s = (a[31] != b[31]) ? a[31] : (a < b);  // differing signs decide alone.
		r = a;
		case (cop)
			CMP_OP_EQ:  r = (a == b) ? 32'd1 : 32'd0;
			CMP_OP_NE:  r = (a != b) ? 32'd1 : 32'd0;
			CMP_OP_LT:  r = lt_s ? 32'd1 : 32'd0;
			CMP_OP_LTU: r = (a < b) ? 32'd1 : 32'd0;
			default: begin
				case (op)
					ALU_OP_ADD: r = a + b;
					ALU_OP_SUB: r = a + ~b + 32'd1;
					ALU_OP_AND: r = a & b;
					ALU_OP_OR:  r = a | b;
					ALU_OP_XOR: r = a ^ b;
					ALU_OP_SLL: r = a << sh;
					ALU_OP_SRL: r = a >> sh;
					ALU_OP_SRA: r = ext[31:0];
					default:    r = a;
				endcase
			end
		endcase
		return r;
	endfunction

	task automatic drive_row(input vec_row_t r);
		stall          <= r.stall;
		flush          <= r.flush;
		id_en          <= r.en;
		id_alu_op      <= r.alu_op;
		id_alu_a       <= r.a;
		id_alu_b       <= r.b;
		id_cmp_op      <= r.cmp_op;
		id_mem_op      <= r.mem_op;
		id_mem_wr_data <= r.wr_data;
		id_dst_addr    <= r.dst;
		id_gpr_we_n    <= r.we_n;
	endtask

	task automatic check_registered(input vec_row_t r);
		check_value("ex_en", word_data_t'(r.exp_en), word_data_t'(ex_en));
		check_value("ex_mem_op", word_data_t'(r.exp_mem_op), word_data_t'(ex_mem_op));
		check_value("ex_mem_wr_data", r.exp_wr_data, ex_mem_wr_data);
		check_value("ex_dst_addr", word_data_t'(r.exp_dst), word_data_t'(ex_dst_addr));
		check_value("ex_gpr_we_n", word_data_t'(r.exp_we_n), word_data_t'(ex_gpr_we_n));
		check_value("ex_out", r.exp_out, ex_out);
	endtask

	initial begin
		vec_row_t row;
		vec_row_t prev;
		reset <= 1'b1;
		drive_row(BUBBLE_ROW);
		prev = BUBBLE_ROW;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_registered(BUBBLE_ROW);
		end
		@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_registered(BUBBLE_ROW);  // still a bubble right after release.

		for (int i = 0; i < NUM_ROWS; i++) begin
			row = VECTORS[i];
			if (row.rand_ops) begin
				row.a = $random(seed);
				row.b = $random(seed);
				row.exp_out = model_result(row.alu_op, row.cmp_op, row.a, row.b);
			end
			@(posedge clk);
			drive_row(row);
			@(negedge clk);
			check_value("access_mem", word_data_t'(row.exp_access), word_data_t'(access_mem));
			check_registered(prev);  // row before was sampled at this edge.
			prev = row;
		end
		@(posedge clk);
		drive_row(BUBBLE_ROW);
		@(negedge clk);
		check_registered(prev);

		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: ex_stage.f
+incdir+dv
logic/cpu_pkg.sv
logic/ex_alu.sv
logic/ex_cmp.sv
logic/ex_reg.sv
logic/ex_stage.sv
dv/ex_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the ex_stage testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module ex_stage_tb \
	-f ex_stage.f -o ex_stage_sim > build.log 2>&1 \
	&& ./obj_dir/ex_stage_sim > sim.log 2>&1 \
	|| echo "build or simulation returned an error status"

cat sim.log 2>/dev/null
grep -q "Something failed" sim.log 2>/dev/null && { echo "simulation FAILED"; exit 1; }
grep -q "Everything OK" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation FAILED, see build.log and sim.log"; exit 1; }
